// File: list.f
source/CsrTypes.sv
source/TrapTypes.sv
source/CsrCommandDecoder.sv
source/CsrCommandQueue.sv
source/CsrFile.sv
source/CsrSubsystem.sv
+incdir+testbench
testbench/CsrSubsystemTb.sv

// File: run.sh
#!/bin/sh
# Builds the CSR subsystem testbench with Verilator and runs it
rm -rf obj_dir sim.log
verilator --binary --timing -f list.f --top-module CsrSubsystemTb -o simCsr > sim.log 2>&1 \
    && ./obj_dir/simCsr >> sim.log 2>&1 \
    || echo "Test failed" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0

// File: source/CsrCommandDecoder.sv
// ======================================================================
// CSR command decoder
// Turns SYSTEM instruction words into CSR requests, combinationally
// ======================================================================

`timescale 1ns/1ps

module CsrCommandDecoder
    import CsrTypes::*;
    import TrapTypes::*;
(
    input  logic      instrValid,
    input  InstrIssue instrPayload,
    output logic      instrReady,
    output logic      reqValid,
    output CsrRequest request,
    input  logic      reqReady
);

    logic [6:0]      opcode;
    logic [4:0]      rdField;
    logic [4:0]      rs1Field;
    logic [11:0]     immField;
    logic            useImmediate;
    SystemFunct3     funct3;
    logic [XLEN-1:0] csrOperand;

    assign opcode       = instrPayload.instruction[6:0];
    assign rdField      = instrPayload.instruction[11:7];
    assign funct3       = SystemFunct3'(instrPayload.instruction[14:12]);
    assign rs1Field     = instrPayload.instruction[19:15];
    assign immField     = instrPayload.instruction[31:20];
    assign useImmediate = instrPayload.instruction[14];

    assign csrOperand = useImmediate ? XLEN'(rs1Field) : instrPayload.rs1Value;

    // Pure translation stage, the queue does the flow control
    assign reqValid   = instrValid;
    assign instrReady = reqReady;

    always_comb begin
        // Illegal instruction unless recognized below
        request.op        = TrapEnter;
        request.csrNumber = immField;
        request.operand   = csrOperand;
        request.cause     = CauseIllegal;
        request.pc        = instrPayload.pc;
        request.tval      = instrPayload.instruction;

        if (opcode == OpcodeSystem) begin
            case (funct3)
                Funct3Priv: begin
                    if (rdField == '0 && rs1Field == '0) begin
                        if (immField == ImmEcall) begin
                            request.cause = CauseEcall;
                            request.tval  = instrPayload.pc;
                        end else if (immField == ImmEbreak) begin
                            request.cause = CauseBreak;
                            request.tval  = instrPayload.pc;
                        end else if (immField == ImmMret) begin
                            request.op   = TrapReturn;
                            request.tval = '0;
                        end
                    end
                end
                Funct3Csrrw, Funct3Csrrwi: begin
                    request.op   = CsrWrite;
                    request.tval = '0;
                end
                Funct3Csrrs, Funct3Csrrsi: begin
                    request.op   = (rs1Field == '0) ? CsrRead : CsrSet; // x0 means no write
                    request.tval = '0;
                end
                Funct3Csrrc, Funct3Csrrci: begin
                    request.op   = (rs1Field == '0) ? CsrRead : CsrClear;
                    request.tval = '0;
                end
                default: request.op = TrapEnter;    // funct3 100 is reserved
            endcase
        end
    end

endmodule

// File: source/CsrCommandQueue.sv
// ======================================================================
// CSR command queue
// Registered circular FIFO of CSR requests with valid/ready on both
// sides, no bypass from input to output
// ======================================================================

`timescale 1ns/1ps

module CsrCommandQueue
    import TrapTypes::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      inValid,
    input  CsrRequest inData,
    output logic      inReady,
    output logic      outValid,
    output CsrRequest outData,
    input  logic      outReady
);

    CsrRequest                  storage [QueueDepth];
    logic [QueueIndexWidth-1:0] writePtr;
    logic [QueueIndexWidth-1:0] readPtr;
    logic [QueueCountWidth-1:0] count;
    logic                       pushEnable;
    logic                       popEnable;

    function automatic logic [QueueIndexWidth-1:0] nextPtr(
        input logic [QueueIndexWidth-1:0] ptr
    );
        if (ptr == QueueIndexWidth'(QueueDepth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign inReady    = (count != QueueCountWidth'(QueueDepth));
    assign outValid   = (count != '0);
    assign outData    = storage[readPtr];
    assign pushEnable = inValid && inReady;
    assign popEnable  = outValid && outReady;

    always_ff @(posedge clock) begin
        if (reset) begin
            writePtr <= '0;
            readPtr  <= '0;
            count    <= '0;
        end else begin
            if (pushEnable) writePtr <= nextPtr(writePtr);
            if (popEnable) readPtr <= nextPtr(readPtr);
            // Count unchanged when both sides fire
            case ({pushEnable, popEnable})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (pushEnable) begin
            storage[writePtr] <= inData;
        end
    end

endmodule

// File: source/CsrFile.sv
// ======================================================================
// Machine-mode CSR file
// Holds the CSR state, executes one queued request per cycle,
// handles trap entry and MRET and produces the response stream
// ======================================================================

`timescale 1ns/1ps

module CsrFile
    import CsrTypes::*;
    import TrapTypes::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       reqValid,
    input  CsrRequest  request,
    output logic       reqReady,
    output logic       respValid,
    output CsrResponse response,
    input  logic       respReady,
    input  logic       timerRequest,
    output logic       interruptPending,
    output CsrState    csrView
);

    CsrState         csrReg;
    CsrState         csrNext;
    CsrResponse      respNext;
    logic [XLEN-1:0] oldValue;
    logic [XLEN-1:0] writeValue;
    logic            csrKnown;
    logic            consume;
    CsrOp            execOp;
    TrapCause        execCause;
    logic [XLEN-1:0] execTval;

    // Take a request when the response slot is free or draining
    assign reqReady = !respValid || respReady;
    assign consume  = reqValid && reqReady;

    assign interruptPending = csrReg.mstatus.mie && csrReg.mie.mtie && csrReg.mip.mtip;
    assign csrView          = csrReg;

    // Read the addressed CSR
    always_comb begin
        csrKnown = 1'b1;
        case (request.csrNumber)
            CsrNumMstatus:  oldValue = csrReg.mstatus;
            CsrNumMie:      oldValue = csrReg.mie;
            CsrNumMip:      oldValue = csrReg.mip;
            CsrNumMtvec:    oldValue = csrReg.mtvec;
            CsrNumMepc:     oldValue = csrReg.mepc;
            CsrNumMcause:   oldValue = csrReg.mcause;
            CsrNumMtval:    oldValue = csrReg.mtval;
            CsrNumMscratch: oldValue = csrReg.mscratch;
            CsrNumMcycle:   oldValue = csrReg.mcycle;
            CsrNumMinstret: oldValue = csrReg.minstret;
            default: begin
                oldValue = '0;
                csrKnown = 1'b0;
            end
        endcase
    end

    // Unimplemented CSR numbers become illegal-instruction traps
    always_comb begin
        execOp    = request.op;
        execCause = request.cause;
        execTval  = request.tval;
        if (request.op inside {CsrRead, CsrWrite, CsrSet, CsrClear} && !csrKnown) begin
            execOp    = TrapEnter;
            execCause = CauseIllegal;
            execTval  = XLEN'(request.csrNumber);
        end
    end

    always_comb begin
        case (execOp)
            CsrWrite: writeValue = request.operand;
            CsrSet:   writeValue = oldValue | request.operand;
            CsrClear: writeValue = oldValue & ~request.operand;
            default:  writeValue = oldValue;
        endcase
    end

    always_comb begin
        csrNext = csrReg;
        csrNext.mcycle = csrReg.mcycle + 1'b1;
        respNext = '0;

        if (consume) begin
            if (execOp != TrapEnter) begin
                csrNext.minstret = csrReg.minstret + 1'b1;
            end

            case (execOp)
                CsrWrite, CsrSet, CsrClear: begin
                    // CSR writes come after the counter increments and win
                    case (request.csrNumber)
                        CsrNumMstatus:  csrNext.mstatus  = writeValue;
                        CsrNumMie:      csrNext.mie      = writeValue;
                        CsrNumMtvec:    csrNext.mtvec    = writeValue;
                        CsrNumMepc:     csrNext.mepc     = writeValue;
                        CsrNumMcause:   csrNext.mcause   = writeValue;
                        CsrNumMtval:    csrNext.mtval    = writeValue;
                        CsrNumMscratch: csrNext.mscratch = writeValue;
                        CsrNumMcycle:   csrNext.mcycle   = writeValue;
                        CsrNumMinstret: csrNext.minstret = writeValue;
                        default:        ;                           // mip is read-only
                    endcase
                    respNext.readValue = oldValue;
                end
                TrapEnter: begin
                    csrNext.mstatus.mpie      = csrReg.mstatus.mie;
                    csrNext.mstatus.mie       = 1'b0;
                    csrNext.mepc              = request.pc;
                    csrNext.mtval             = execTval;
                    csrNext.mcause.isInterrupt = 1'b0;
                    csrNext.mcause.code       = 31'(execCause);

                    respNext.redirect = 1'b1;
                    respNext.target   = {csrReg.mtvec[XLEN-1:2], 2'b00};    // Direct mode only
                end
                TrapReturn: begin
                    csrNext.mstatus.mie = csrReg.mstatus.mpie;
                    respNext.redirect   = 1'b1;
                    respNext.target     = csrReg.mepc;
                end
                default: respNext.readValue = oldValue;     // Plain read
            endcase
        end

        // Timer line sampled every cycle
        csrNext.mip.mtip = timerRequest;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            csrReg    <= '0;
            respValid <= 1'b0;
        end else begin
            csrReg <= csrNext;
            if (consume) begin
                respValid <= 1'b1;
            end else if (respReady) begin
                respValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (consume) response <= respNext;
    end

endmodule

// File: source/CsrSubsystem.sv
// ======================================================================
// CSR subsystem top level
// Decoder, request queue and CSR file in one valid/ready pipeline
// ======================================================================

`timescale 1ns/1ps

module CsrSubsystem
    import CsrTypes::*;
    import TrapTypes::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       instrValid,
    input  InstrIssue  instrPayload,
    output logic       instrReady,
    output logic       respValid,
    output CsrResponse response,
    input  logic       respReady,
    input  logic       timerRequest,
    output logic       interruptPending,
    output CsrState    csrView
);

    logic      decReqValid;
    CsrRequest decRequest;
    logic      decReqReady;
    logic      deqValid;
    CsrRequest deqRequest;
    logic      deqReady;

    CsrCommandDecoder CsrCommandDecoder_inst (
        .instrValid   (instrValid),
        .instrPayload (instrPayload),
        .instrReady   (instrReady),
        .reqValid     (decReqValid),
        .request      (decRequest),
        .reqReady     (decReqReady)
    );

    CsrCommandQueue CsrCommandQueue_inst (
        .clock    (clock),
        .reset    (reset),
        .inValid  (decReqValid),
        .inData   (decRequest),
        .inReady  (decReqReady),
        .outValid (deqValid),
        .outData  (deqRequest),
        .outReady (deqReady)
    );

    CsrFile CsrFile_inst (
        .clock            (clock),
        .reset            (reset),
        .reqValid         (deqValid),
        .request          (deqRequest),
        .reqReady         (deqReady),
        .respValid        (respValid),
        .response         (response),
        .respReady        (respReady),
        .timerRequest     (timerRequest),
        .interruptPending (interruptPending),
        .csrView          (csrView)
    );

endmodule

// File: source/CsrTypes.sv
// ======================================================================
// CSR type definitions
// Machine-mode CSR addresses, the CSR operation encoding and the
// layouts of the registers held by the CSR file
// ======================================================================

package CsrTypes;

    localparam int XLEN = 32;

    typedef logic [11:0] CsrNumber;

    // Implemented machine-mode CSR addresses
    localparam CsrNumber CsrNumMstatus  = 12'h300;
    localparam CsrNumber CsrNumMie      = 12'h304;
    localparam CsrNumber CsrNumMip      = 12'h344;
    localparam CsrNumber CsrNumMtvec    = 12'h305;
    localparam CsrNumber CsrNumMepc     = 12'h341;
    localparam CsrNumber CsrNumMcause   = 12'h342;
    localparam CsrNumber CsrNumMtval    = 12'h343;
    localparam CsrNumber CsrNumMscratch = 12'h340;
    localparam CsrNumber CsrNumMcycle   = 12'hB00;
    localparam CsrNumber CsrNumMinstret = 12'hB02;

    // What a queued request does to the CSR file
    typedef enum logic [2:0] {
        CsrRead,
        CsrWrite,
        CsrSet,
        CsrClear,
        TrapEnter,
        TrapReturn
    } CsrOp;

    typedef struct packed {
        logic [23:0] reservedHigh;
        logic        mpie;          // Bit 7
        logic [2:0]  reservedMid;
        logic        mie;           // Bit 3, global enable
        logic [2:0]  reservedLow;
    } Mstatus;

    typedef struct packed {
        logic [23:0] reservedHigh;
        logic        mtip;          // Timer interrupt pending
        logic [6:0]  reservedLow;
    } Mip;

    typedef struct packed {
        logic [23:0] reservedHigh;
        logic        mtie;          // Timer interrupt enable
        logic [6:0]  reservedLow;
    } Mie;

    typedef struct packed {
        logic        isInterrupt;
        logic [30:0] code;
    } Mcause;

    // Whole register set of the CSR file
    typedef struct packed {
        Mstatus            mstatus;
        Mie                mie;
        Mip                mip;
        logic [XLEN-1:0]   mtvec;
        logic [XLEN-1:0]   mepc;
        Mcause             mcause;
        logic [XLEN-1:0]   mtval;
        logic [XLEN-1:0]   mscratch;
        logic [XLEN-1:0]   mcycle;
        logic [XLEN-1:0]   minstret;
    } CsrState;

endpackage

// File: source/TrapTypes.sv
// ======================================================================
// Trap and request type definitions
// Instruction issue payload, trap causes, SYSTEM instruction fields
// and the request and response records passed between blocks
// ======================================================================

package TrapTypes;
    import CsrTypes::*;

    localparam logic [6:0]  OpcodeSystem = 7'b1110011;
    localparam logic [11:0] ImmEcall     = 12'h000;
    localparam logic [11:0] ImmEbreak    = 12'h001;
    localparam logic [11:0] ImmMret      = 12'h302;

    localparam int QueueDepth      = 4;
    localparam int QueueIndexWidth = $clog2(QueueDepth);
    localparam int QueueCountWidth = $clog2(QueueDepth + 1);

    typedef enum logic [2:0] {
        Funct3Priv   = 3'b000,
        Funct3Csrrw  = 3'b001,
        Funct3Csrrs  = 3'b010,
        Funct3Csrrc  = 3'b011,
        Funct3Csrrwi = 3'b101,
        Funct3Csrrsi = 3'b110,
        Funct3Csrrci = 3'b111
    } SystemFunct3;

    // Synchronous exception codes written to mcause
    typedef enum logic [3:0] {
        CauseIllegal = 4'd2,
        CauseBreak   = 4'd3,
        CauseEcall   = 4'd11
    } TrapCause;

    typedef struct packed {
        logic [XLEN-1:0] instruction;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rs1Value;
    } InstrIssue;

    typedef struct packed {
        CsrOp            op;
        CsrNumber        csrNumber;
        logic [XLEN-1:0] operand;    // rs1 value or zero-extended immediate
        TrapCause        cause;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] tval;
    } CsrRequest;

    typedef struct packed {
        logic [XLEN-1:0] readValue;
        logic            redirect;
        logic [XLEN-1:0] target;
    } CsrResponse;

endpackage

// File: testbench/CsrTests.svh
// ======================================================================
// Directed tests for the CSR subsystem
// Included into the testbench module, one task per behavior
// ======================================================================

`ifndef CSR_TESTS_SVH
`define CSR_TESTS_SVH

task automatic testResetState();
    startTest("reset state");
    @(negedge clock);
    checkWord("instrReady", 32'd1, {31'd0, instrReady});
    checkWord("respValid", 32'd0, {31'd0, respValid});
    checkWord("interruptPending", 32'd0, {31'd0, interruptPending});
    checkWord("mstatus", 32'd0, csrView.mstatus);
    checkWord("mtvec", 32'd0, csrView.mtvec);
    @(posedge clock);
    #2;
    finishTest();
endtask

task automatic testReadWrite();
    startTest("read write");
    for (int i = 0; i < 3; i++) begin
        csrAccess(Funct3Csrrw, CsrNumMscratch, 5'd5, $random(seed), "csrrw mscratch");
        csrAccess(Funct3Csrrs, CsrNumMscratch, 5'd6, $random(seed), "csrrs mscratch");
        csrAccess(Funct3Csrrc, CsrNumMscratch, 5'd7, $random(seed), "csrrc mscratch");
        csrAccess(Funct3Csrrwi, CsrNumMscratch, 5'(i + 9), '0, "csrrwi mscratch");
        csrAccess(Funct3Csrrw, CsrNumMtvec, 5'd1, $random(seed), "csrrw mtvec");
        csrAccess(Funct3Csrrsi, CsrNumMtvec, 5'($random(seed)), '0, "csrrsi mtvec");
        csrAccess(Funct3Csrrci, CsrNumMtvec, 5'($random(seed)), '0, "csrrci mtvec");
        csrAccess(Funct3Csrrs, CsrNumMscratch, 5'd0, '0, "read mscratch");
    end
    finishTest();
endtask

// Trap entry, CSR inspection, then MRET back
task automatic trapRoundTrip(input logic [XLEN-1:0] word, input TrapCause cause,
                             input logic [XLEN-1:0] code, input string detail);
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] value;
    pc = pcCounter;
    trapOnly(word, '0, cause, pc, detail);
    readCsr(CsrNumMepc, value);
    checkWord({detail, " mepc"}, pc, value);
    readCsr(CsrNumMcause, value);
    checkWord({detail, " mcause"}, code, value);
    readCsr(CsrNumMstatus, value);
    checkWord({detail, " mpie and mie"}, 32'd2, {30'd0, value[7], value[3]});
    returnFromTrap({detail, " mret"});
    readCsr(CsrNumMstatus, value);
    checkWord({detail, " mie after mret"}, 32'd1, {31'd0, value[3]});
endtask

task automatic testTraps();
    startTest("traps");
    csrAccess(Funct3Csrrw, CsrNumMtvec, 5'd1, $random(seed), "mtvec setup");
    csrAccess(Funct3Csrrsi, CsrNumMstatus, 5'd8, '0, "mie on");
    trapRoundTrip(encodePriv(12'h000), CauseEcall, 32'd11, "ecall");
    trapRoundTrip(encodePriv(12'h001), CauseBreak, 32'd3, "ebreak");
    finishTest();
endtask

task automatic testIllegal();
    logic [XLEN-1:0] value;
    startTest("illegal");
    trapOnly(32'h0000_0013, '0, CauseIllegal, 32'h0000_0013, "addi opcode");
    readCsr(CsrNumMcause, value);
    checkWord("addi mcause", 32'd2, value);
    readCsr(CsrNumMtval, value);
    checkWord("addi mtval", 32'h0000_0013, value);
    csrAccess(Funct3Csrrw, CsrNumMcause, 5'd1, '0, "mcause clear");
    // 0x7C0 is an unimplemented custom CSR
    trapOnly(encodeCsr(Funct3Csrrw, 12'h7C0, 5'd1), $random(seed), CauseIllegal,
             32'h0000_07C0, "unknown csr");
    readCsr(CsrNumMcause, value);
    checkWord("unknown csr mcause", 32'd2, value);
    readCsr(CsrNumMtval, value);
    checkWord("unknown csr mtval", 32'h0000_07C0, value);
    finishTest();
endtask

task automatic testBackPressure();
    logic [XLEN-1:0] values [6];
    CsrResponse      expected [6];
    logic            stalled;
    int              waitCycles;
    startTest("back-pressure");
    for (int i = 0; i < 6; i++) begin
        values[i] = $random(seed);
        expected[i].readValue = shadow[CsrNumMscratch];    // Chain of old values
        expected[i].redirect = 1'b0;
        expected[i].target = '0;
        shadow[CsrNumMscratch] = values[i];
    end
    for (int i = 0; i < 5; i++) begin
        sendInstr(encodeCsr(Funct3Csrrw, CsrNumMscratch, 5'd1), values[i]);
    end
    stalled = 1'b0;
    waitCycles = 0;
    while (!stalled && waitCycles < WaitLimit) begin
        @(negedge clock);
        stalled = !instrReady;
        @(posedge clock);
        #2;
        waitCycles++;
    end
    if (!stalled) begin
        $display("%s: instrReady stayed high while responses were held", testName);
        errorCount++;
    end
    fork
        sendInstr(encodeCsr(Funct3Csrrw, CsrNumMscratch, 5'd1), values[5]);
        begin
            for (int i = 0; i < 6; i++) expectResponse($sformatf("response %0d", i), expected[i]);
        end
    join
    finishTest();
endtask

task automatic testCounters();
    logic [XLEN-1:0] first;
    logic [XLEN-1:0] second;
    startTest("counters and timer");
    readCsr(CsrNumMcycle, first);
    readCsr(CsrNumMcycle, second);
    if (second <= first) begin
        $display("error %s (mcycle): expected above %h, actual %h", testName, first, second);
        errorCount++;
    end
    readCsr(CsrNumMinstret, first);
    csrAccess(Funct3Csrrw, CsrNumMscratch, 5'd2, $random(seed), "mscratch write");
    csrAccess(Funct3Csrrs, CsrNumMscratch, 5'd0, '0, "mscratch read");
    csrAccess(Funct3Csrrs, CsrNumMtvec, 5'd0, '0, "mtvec read");
    trapOnly(32'h0000_0013, '0, CauseIllegal, 32'h0000_0013, "trap not counted");
    readCsr(CsrNumMinstret, second);
    checkWord("minstret step", first + 32'd4, second);     // First read plus three CSR ops

    timerRequest = 1'b1;
    csrAccess(Funct3Csrrci, CsrNumMstatus, 5'd8, '0, "mie off");
    csrAccess(Funct3Csrrw, CsrNumMie, 5'd1, 32'h0000_0080, "mtie on");
    checkPending(1'b0, "global enable off");
    csrAccess(Funct3Csrrsi, CsrNumMstatus, 5'd8, '0, "mie on");
    checkPending(1'b1, "all enables set");
    csrAccess(Funct3Csrrw, CsrNumMip, 5'd1, 32'hFFFF_FFFF, "mip write");
    csrAccess(Funct3Csrrs, CsrNumMip, 5'd0, '0, "mip after write");
    timerRequest = 1'b0;
    checkPending(1'b0, "timer low");
    csrAccess(Funct3Csrrs, CsrNumMip, 5'd0, '0, "mip timer low");
    finishTest();
endtask

`endif

// File: testbench/CsrSubsystemTb.sv
// ======================================================================
// CSR subsystem testbench
// Drives SYSTEM instructions into the subsystem and checks every
// response against a shadow model of the machine-mode CSRs
// ======================================================================

`timescale 1ns/1ps

module CsrSubsystemTb
    import CsrTypes::*;
    import TrapTypes::*;
();

    localparam int WaitLimit = 40;  // Cycles per handshake wait

    logic       clock;
    logic       reset;
    logic       instrValid;
    InstrIssue  instrPayload;
    logic       instrReady;
    logic       respValid;
    CsrResponse response;
    logic       respReady;
    logic       timerRequest;
    logic       interruptPending;
    CsrState    csrView;

    logic [XLEN-1:0] shadow [4096];     // Expected CSR contents by address
    logic [XLEN-1:0] pcCounter;
    integer          seed;
    int              errorCount;
    int              testCount;
    int              startErrors;
    string           testName;

    CsrSubsystem CsrSubsystem_inst (
        .clock            (clock),
        .reset            (reset),
        .instrValid       (instrValid),
        .instrPayload     (instrPayload),
        .instrReady       (instrReady),
        .respValid        (respValid),
        .response         (response),
        .respReady        (respReady),
        .timerRequest     (timerRequest),
        .interruptPending (interruptPending),
        .csrView          (csrView)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Zicsr forms, rd is always x1
    function automatic logic [XLEN-1:0] encodeCsr(input SystemFunct3 f3, input CsrNumber csr,
                                                  input logic [4:0] rs1);
        return {csr, rs1, f3, 5'd1, 7'b1110011};
    endfunction

    // ECALL, EBREAK and MRET differ only in the immediate
    function automatic logic [XLEN-1:0] encodePriv(input logic [11:0] imm);
        return {imm, 13'd0, 7'b1110011};
    endfunction

    task automatic abortRun(input string what);
        $display("%s stopped: %s", testName, what);
        $display("%0d tests run, %0d errors", testCount, errorCount);
        $display("Test failed");
        $finish;
    endtask

    task automatic startTest(input string name);
        testName = name;
        startErrors = errorCount;
        testCount++;
    endtask

    task automatic finishTest();
        $display("%s finished with %0d errors", testName, errorCount - startErrors);
    endtask

    task automatic checkWord(input string detail, input logic [XLEN-1:0] expected,
                             input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("error %s (%s): expected %h, actual %h", testName, detail, expected, actual);
            errorCount++;
        end
    endtask

    task automatic sendInstr(input logic [XLEN-1:0] word, input logic [XLEN-1:0] rs1Value);
        int   waitCycles;
        logic accepted;
        waitCycles = 0;
        accepted = 1'b0;
        instrValid = 1'b1;
        instrPayload.instruction = word;
        instrPayload.pc = pcCounter;
        instrPayload.rs1Value = rs1Value;
        while (!accepted) begin
            if (waitCycles == WaitLimit) abortRun("instrReady stayed low");
            @(negedge clock);
            accepted = instrReady;  // Transfer happens at the next edge
            @(posedge clock);
            #2;
            waitCycles++;
        end
        instrValid = 1'b0;
        pcCounter = pcCounter + 32'd4;
    endtask

    task automatic getResponse(output CsrResponse got);
        int   waitCycles;
        logic seen;
        waitCycles = 0;
        seen = 1'b0;
        respReady = 1'b1;
        while (!seen) begin
            if (waitCycles == WaitLimit) abortRun("respValid never rose");
            @(negedge clock);
            seen = respValid;
            got = response;
            @(posedge clock);
            #2;
            waitCycles++;
        end
        respReady = 1'b0;
    endtask

    task automatic expectResponse(input string detail, input CsrResponse expected);
        CsrResponse got;
        getResponse(got);
        if (got !== expected) begin
            $display("error %s (%s): expected %h, actual %h", testName, detail, expected, got);
            errorCount++;
        end
    endtask

    task automatic readCsr(input CsrNumber csr, output logic [XLEN-1:0] value);
        CsrResponse got;
        sendInstr(encodeCsr(Funct3Csrrs, csr, 5'd0), '0);
        getResponse(got);
        value = got.readValue;
    endtask

    // Read-modify-write through the model, checks the old value
    task automatic csrAccess(input SystemFunct3 f3, input CsrNumber csr, input logic [4:0] rs1,
                             input logic [XLEN-1:0] rs1Value, input string detail);
        logic [XLEN-1:0] operand;
        logic [XLEN-1:0] oldValue;
        logic [XLEN-1:0] newValue;
        CsrResponse      expected;
        operand = (f3 inside {Funct3Csrrwi, Funct3Csrrsi, Funct3Csrrci}) ? XLEN'(rs1) : rs1Value;
        oldValue = (csr == CsrNumMip) ? {24'd0, timerRequest, 7'd0} : shadow[csr];
        case (f3)
            Funct3Csrrw, Funct3Csrrwi: newValue = operand;
            Funct3Csrrs, Funct3Csrrsi: newValue = (rs1 == 5'd0) ? oldValue : oldValue | operand;
            default:                   newValue = (rs1 == 5'd0) ? oldValue : oldValue & ~operand;
        endcase
        expected.readValue = oldValue;
        expected.redirect = 1'b0;
        expected.target = '0;
        sendInstr(encodeCsr(f3, csr, rs1), rs1Value);
        expectResponse(detail, expected);
        if (csr != CsrNumMip) shadow[csr] = newValue;   // mip ignores writes
    endtask

    task automatic trapOnly(input logic [XLEN-1:0] word, input logic [XLEN-1:0] rs1Value,
                            input TrapCause cause, input logic [XLEN-1:0] tval,
                            input string detail);
        CsrResponse expected;
        Mstatus     status;
        expected.readValue = '0;
        expected.redirect = 1'b1;
        expected.target = {shadow[CsrNumMtvec][XLEN-1:2], 2'b00};
        status = shadow[CsrNumMstatus];
        status.mpie = status.mie;
        status.mie = 1'b0;
        shadow[CsrNumMstatus] = status;
        shadow[CsrNumMepc] = pcCounter;     // pc of the trapping instruction
        shadow[CsrNumMtval] = tval;
        shadow[CsrNumMcause] = {1'b0, 31'(cause)};
        sendInstr(word, rs1Value);
        expectResponse(detail, expected);
    endtask

    task automatic returnFromTrap(input string detail);
        CsrResponse expected;
        Mstatus     status;
        expected.readValue = '0;
        expected.redirect = 1'b1;
        expected.target = shadow[CsrNumMepc];
        status = shadow[CsrNumMstatus];
        status.mie = status.mpie;
        shadow[CsrNumMstatus] = status;
        sendInstr(encodePriv(12'h302), '0);
        expectResponse(detail, expected);
    endtask

    task automatic checkPending(input logic expected, input string detail);
        @(posedge clock);
        @(negedge clock);
        if (interruptPending !== expected) begin
            $display("error %s (%s): expected %b, actual %b", testName, detail, expected,
                     interruptPending);
            errorCount++;
        end
        @(posedge clock);
        #2;
    endtask

`include "CsrTests.svh"

    initial begin
        reset = 1'b1;
        instrValid = 1'b0;
        instrPayload = '0;
        respReady = 1'b0;
        timerRequest = 1'b0;
        seed = 32'h2568;
        pcCounter = 32'h0000_0100;
        errorCount = 0;
        testCount = 0;
        startErrors = 0;
        testName = "setup";
        for (int i = 0; i < 4096; i++) shadow[i] = '0;
        repeat (5) @(posedge clock);
        #2;
        reset = 1'b0;

        testResetState();
        testReadWrite();
        testTraps();
        testIllegal();
        testBackPressure();
        testCounters();

        $display("%0d tests run, %0d errors", testCount, errorCount);
        if (errorCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
